/* src/spi_slave_pkg.sv */
package spi_slave_pkg;

    // =========================================================================
    // Widths and transfer shape
    // =========================================================================
    localparam int unsigned byte_w         = 8;
    localparam int unsigned head_bytes     = 2;
    localparam int unsigned rd_dummy_bytes = 1;

    typedef logic [byte_w-1:0] byte_t;
    typedef logic [1:0]        bank_t;

    localparam bank_t bank_sys = 2'd0;
    localparam bank_t bank_pat = 2'd1;
    localparam bank_t bank_eep = 2'd2;

    // Special addresses
    localparam byte_t pat_last_addr   = 8'h7F;
    localparam byte_t erase_ctrl_addr = 8'h03;
    localparam byte_t led_reg_addr    = 8'h04;

    // =========================================================================
    // Pipeline payloads
    // =========================================================================
    typedef struct packed {
        logic [2:0] rsvd;
        logic       rd;
        logic [3:0] bank_sel;
    } cmd_fields_t;

    // Command byte, seen whole or split into fields
    typedef union packed {
        byte_t       raw;
        cmd_fields_t f;
    } cmd_u;

    typedef struct packed {
        byte_t data;
        byte_t idx;
    } rx_byte_t;

    typedef struct packed {
        logic  wr;
        logic  rd;
        bank_t bank;
        byte_t addr;
        byte_t wdata;
        logic  pat_arm;
    } reg_acc_t;

    // Fixed values for addresses without storage
    function automatic byte_t default_rd(bank_t bank, byte_t addr);
        byte_t val;
        val = '0;
        if (bank == bank_sys && addr == 8'h00) val = 8'h94;
        if (bank == bank_sys && addr == 8'h01) val = 8'h25;
        if (bank == bank_eep && addr == 8'h04) val = 8'h0F;
        return val;
    endfunction

    function automatic logic is_writable(bank_t bank, byte_t addr);
        case (bank)
            bank_sys: return (addr == 8'h04) || (addr == 8'h05) ||
                             (addr == 8'hF0) || (addr == 8'hF1);
            bank_pat: return 1'b1;
            bank_eep: return addr <= 8'h03;
            default:  return 1'b0;
        endcase
    endfunction

endpackage

/* src/spi_bus_sampler.sv */
module spi_bus_sampler (
    input  logic sclk_i,
    input  logic rst_n,
    input  logic sck_i,
    input  logic cs_n_i,
    input  logic mosi_i,
    output logic sck_rise_o,
    output logic sck_fall_o,
    output logic cs_start_o,
    output logic cs_active_o,
    output logic mosi_o
);
    typedef struct packed {
        logic sck;
        logic cs_n;
        logic mosi;
    } pins_t;

    // Idle bus: clock low, select high
    localparam pins_t pins_idle = '{sck: 1'b0, cs_n: 1'b1, mosi: 1'b0};

    pins_t sync1_q;
    pins_t sync2_q;
    pins_t hist_q;

    // Two sync flops, then one history stage for edge detection
    always_ff @(posedge sclk_i or negedge rst_n) begin
        if (!rst_n) begin
            sync1_q     <= pins_idle;
            sync2_q     <= pins_idle;
            hist_q      <= pins_idle;
            sck_rise_o  <= 1'b0;
            sck_fall_o  <= 1'b0;
            cs_start_o  <= 1'b0;
            cs_active_o <= 1'b0;
            mosi_o      <= 1'b0;
        end
        else begin
            sync1_q     <= '{sck: sck_i, cs_n: cs_n_i, mosi: mosi_i};
            sync2_q     <= sync1_q;
            hist_q      <= sync2_q;
            sck_rise_o  <= sync2_q.sck & ~hist_q.sck & ~sync2_q.cs_n;
            sck_fall_o  <= ~sync2_q.sck & hist_q.sck & ~sync2_q.cs_n;
            cs_start_o  <= ~sync2_q.cs_n & hist_q.cs_n;
            cs_active_o <= ~sync2_q.cs_n;
            mosi_o      <= sync2_q.mosi;
        end
    end

    // SCK stays high at least 6 cycles so the next transmit byte is ready
    a_one_edge: assert property (@(posedge sclk_i) disable iff (!rst_n)
        sck_rise_o |-> (!sck_fall_o) [*6]);

endmodule

/* src/spi_byte_deserializer.sv */
module spi_byte_deserializer (
    input  logic                    sclk_i,
    input  logic                    rst_n,
    input  logic                    sck_rise_i,
    input  logic                    cs_start_i,
    input  logic                    mosi_i,
    output spi_slave_pkg::rx_byte_t rx_o,
    output logic                    rx_valid_o
);
    import spi_slave_pkg::*;

    byte_t      shift_q;
    logic [2:0] bit_cnt_q;
    byte_t      idx_q;
    logic       byte_done;

    assign byte_done = sck_rise_i && (bit_cnt_q == 3'd7);

    // Bit and byte counters
    always_ff @(posedge sclk_i or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt_q  <= '0;
            idx_q      <= '0;
            rx_valid_o <= 1'b0;
        end
        else if (cs_start_i) begin
            bit_cnt_q  <= '0;
            idx_q      <= '0;
            rx_valid_o <= 1'b0;
        end
        else begin
            rx_valid_o <= byte_done;
            if (sck_rise_i) begin
                bit_cnt_q <= bit_cnt_q + 3'd1;
            end
            // Index sticks at FF so a long burst never looks like a header
            if (byte_done && idx_q != 8'hFF) begin
                idx_q <= idx_q + 8'd1;
            end
        end
    end

    // MSB first
    always_ff @(posedge sclk_i) begin
        if (sck_rise_i) begin
            shift_q <= {shift_q[6:0], mosi_i};
        end
        if (byte_done) begin
            rx_o <= '{data: {shift_q[6:0], mosi_i}, idx: idx_q};
        end
    end

endmodule

/* src/spi_cmd_decoder.sv */
module spi_cmd_decoder (
    input  logic                    sclk_i,
    input  logic                    rst_n,
    input  spi_slave_pkg::rx_byte_t rx_i,
    input  logic                    rx_valid_i,
    input  logic                    cs_active_i,
    output spi_slave_pkg::reg_acc_t acc_o,
    output logic                    acc_valid_o,
    output spi_slave_pkg::byte_t    cmd_o
);
    import spi_slave_pkg::*;

    cmd_u  cmd_q;
    byte_t addr_q;
    logic  pat_arm_q;
    bank_t cur_bank;
    logic  cur_rd;
    logic  is_cmd_byte;
    logic  is_addr_byte;
    logic  is_data_byte;
    logic  wr_ok;

    // Bank nibble, unknown codes fall back to SYS
    always_comb begin
        case (cmd_q.f.bank_sel)
            4'h8:    cur_bank = bank_sys;
            4'h4:    cur_bank = bank_pat;
            4'h2:    cur_bank = bank_eep;
            default: cur_bank = bank_sys;
        endcase
    end

    assign cur_rd       = cmd_q.f.rd;
    assign cmd_o        = cmd_q.raw;
    assign is_cmd_byte  = (rx_i.idx == 8'd0);
    assign is_addr_byte = (rx_i.idx == byte_t'(head_bytes - 1));
    assign is_data_byte = (rx_i.idx >= byte_t'(head_bytes));
    assign wr_ok        = !cur_rd && is_writable(cur_bank, addr_q);

    // =========================================================================
    // Header capture and burst address
    // =========================================================================
    always_ff @(posedge sclk_i or negedge rst_n) begin
        if (!rst_n) begin
            cmd_q.raw   <= '0;
            addr_q      <= '0;
            pat_arm_q   <= 1'b0;
            acc_valid_o <= 1'b0;
        end
        else if (!cs_active_i) begin
            pat_arm_q   <= 1'b0;
            acc_valid_o <= 1'b0;
        end
        else begin
            acc_valid_o <= 1'b0;
            if (rx_valid_i && is_cmd_byte) begin
                cmd_q.raw <= rx_i.data;
            end
            else if (rx_valid_i && is_addr_byte) begin
                addr_q    <= rx_i.data;
                pat_arm_q <= !cur_rd && (cur_bank == bank_pat) && (rx_i.data == 8'h00);
                // Reads get a dummy slot ahead of the first data byte
                acc_valid_o <= cur_rd;
            end
            else if (rx_valid_i && is_data_byte) begin
                addr_q      <= addr_q + 8'd1;
                acc_valid_o <= cur_rd || wr_ok;
            end
        end
    end

    // Access payload, dummy slot has neither flag set
    always_ff @(posedge sclk_i) begin
        if (rx_valid_i) begin
            acc_o.wr      <= wr_ok && is_data_byte;
            acc_o.rd      <= cur_rd && is_data_byte;
            acc_o.bank    <= cur_bank;
            acc_o.addr    <= addr_q;
            acc_o.wdata   <= rx_i.data;
            acc_o.pat_arm <= pat_arm_q;
        end
    end

    a_acc_in_frame: assert property (@(posedge sclk_i) disable iff (!rst_n)
        acc_valid_o |-> cs_active_i);

endmodule

/* src/spi_reg_bank.sv */
module spi_reg_bank (
    input  logic                    sclk_i,
    input  logic                    rst_n,
    input  spi_slave_pkg::reg_acc_t acc_i,
    input  logic                    acc_valid_i,
    input  logic                    cfg_rd_i,
    input  spi_slave_pkg::bank_t    cfg_bank_i,
    input  spi_slave_pkg::byte_t    cfg_addr_i,
    output spi_slave_pkg::byte_t    cfg_rdata_o,
    input  logic                    pat_done_clr_i,
    input  logic                    erase_done_clr_i,
    output spi_slave_pkg::byte_t    tx_byte_o,
    output logic                    tx_load_o,
    output logic                    pat_done_o,
    output logic                    erase_done_o,
    output spi_slave_pkg::byte_t    erase_ctrl_o,
    output logic [1:0]              led_o
);
    import spi_slave_pkg::*;

    byte_t sys_q [4];
    byte_t eep_q [4];
    byte_t pat_mem [256];
    logic  wr_en;
    logic  pat_hit;
    logic  erase_hit;

    // SYS 04, 05, F0, F1 map to slots 0..3
    function automatic logic [1:0] sys_idx(byte_t addr);
        return {addr[7], addr[0]};
    endfunction

    function automatic byte_t stored(bank_t bank, byte_t addr);
        byte_t val;
        case (bank)
            bank_sys: val = sys_q[sys_idx(addr)];
            bank_pat: val = pat_mem[addr];
            default:  val = eep_q[addr[1:0]];
        endcase
        return val;
    endfunction

    assign wr_en     = acc_valid_i && acc_i.wr;
    assign pat_hit   = wr_en && acc_i.pat_arm && (acc_i.bank == bank_pat) &&
                       (acc_i.addr == pat_last_addr);
    assign erase_hit = wr_en && (acc_i.bank == bank_eep) && (acc_i.addr == erase_ctrl_addr);
    assign led_o     = sys_q[sys_idx(led_reg_addr)][1:0];

    // =========================================================================
    // Register storage
    // =========================================================================
    always_ff @(posedge sclk_i or negedge rst_n) begin
        if (!rst_n) begin
            sys_q <= '{default: '0};
            eep_q <= '{default: '0};
        end
        else if (wr_en) begin
            case (acc_i.bank)
                bank_sys: sys_q[sys_idx(acc_i.addr)] <= acc_i.wdata;
                bank_eep: eep_q[acc_i.addr[1:0]] <= acc_i.wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge sclk_i) begin
        if (wr_en && acc_i.bank == bank_pat) begin
            pat_mem[acc_i.addr] <= acc_i.wdata;
        end
    end

    // =========================================================================
    // Flags, host port and transmit load
    // =========================================================================
    always_ff @(posedge sclk_i or negedge rst_n) begin
        if (!rst_n) begin
            pat_done_o   <= 1'b0;
            erase_done_o <= 1'b0;
            erase_ctrl_o <= '0;
            cfg_rdata_o  <= '0;
            tx_load_o    <= 1'b0;
        end
        else begin
            if (pat_done_clr_i) begin
                pat_done_o <= 1'b0;
            end
            else if (pat_hit) begin
                pat_done_o <= 1'b1;
            end
            if (erase_done_clr_i) begin
                erase_done_o <= 1'b0;
            end
            else if (erase_hit) begin
                erase_done_o <= 1'b1;
            end
            if (erase_hit) begin
                erase_ctrl_o <= acc_i.wdata;
            end
            // Host sees stored values only
            if (cfg_rd_i) begin
                cfg_rdata_o <= is_writable(cfg_bank_i, cfg_addr_i) ?
                               stored(cfg_bank_i, cfg_addr_i) : 8'h00;
            end
            tx_load_o <= acc_valid_i && !acc_i.wr;
        end
    end

    always_ff @(posedge sclk_i) begin
        if (acc_valid_i && acc_i.rd) begin
            tx_byte_o <= is_writable(acc_i.bank, acc_i.addr) ?
                         stored(acc_i.bank, acc_i.addr) : default_rd(acc_i.bank, acc_i.addr);
        end
        else if (acc_valid_i) begin
            tx_byte_o <= 8'h00;
        end
    end

    a_wr_xor_rd: assert property (@(posedge sclk_i) disable iff (!rst_n)
        acc_valid_i |-> !(acc_i.wr && acc_i.rd));

endmodule

/* src/spi_miso_serializer.sv */
module spi_miso_serializer (
    input  logic                 sclk_i,
    input  logic                 rst_n,
    input  logic                 cs_start_i,
    input  logic                 cs_active_i,
    input  logic                 sck_fall_i,
    input  spi_slave_pkg::byte_t tx_byte_i,
    input  logic                 tx_load_i,
    output logic                 miso_o
);
    import spi_slave_pkg::*;

    byte_t      pend_q;
    byte_t      shift_q;
    logic [2:0] fall_cnt_q;

    assign miso_o = shift_q[7];

    // Shift on falling SCK, next byte enters on the eighth fall
    always_ff @(posedge sclk_i or negedge rst_n) begin
        if (!rst_n) begin
            pend_q     <= '0;
            shift_q    <= '0;
            fall_cnt_q <= '0;
        end
        else if (!cs_active_i || cs_start_i) begin
            pend_q     <= '0;
            shift_q    <= '0;
            fall_cnt_q <= '0;
        end
        else begin
            if (sck_fall_i) begin
                fall_cnt_q <= fall_cnt_q + 3'd1;
                if (fall_cnt_q == 3'd7) begin
                    shift_q <= pend_q;
                    pend_q  <= '0;
                end
                else begin
                    shift_q <= {shift_q[6:0], 1'b0};
                end
            end
            // A late load still lands in the pending slot
            if (tx_load_i) begin
                pend_q <= tx_byte_i;
            end
        end
    end

endmodule

/* src/spi_slave_top.sv */
module spi_slave_top (
    input  logic                 sclk_i,
    input  logic                 rst_n,
    input  logic                 spi_sck_i,
    input  logic                 spi_cs_n_i,
    input  logic                 spi_mosi_i,
    output logic                 spi_miso_o,
    input  logic                 cfg_rd_i,
    input  spi_slave_pkg::bank_t cfg_bank_i,
    input  spi_slave_pkg::byte_t cfg_addr_i,
    output spi_slave_pkg::byte_t cfg_rdata_o,
    input  logic                 pat_done_clr_i,
    input  logic                 erase_done_clr_i,
    output logic                 pat_done_o,
    output logic                 erase_done_o,
    output spi_slave_pkg::byte_t erase_ctrl_o,
    output logic [1:0]           led_o,
    output spi_slave_pkg::byte_t cmd_o
);
    import spi_slave_pkg::*;

    logic     sck_rise;
    logic     sck_fall;
    logic     cs_start;
    logic     cs_active;
    logic     mosi_s;
    rx_byte_t rx;
    logic     rx_valid;
    reg_acc_t acc;
    logic     acc_valid;
    byte_t    tx_byte;
    logic     tx_load;

    // =========================================================================
    // Pipeline stages
    // =========================================================================
    spi_bus_sampler u_sampler (
        .sclk_i      (sclk_i),
        .rst_n       (rst_n),
        .sck_i       (spi_sck_i),
        .cs_n_i      (spi_cs_n_i),
        .mosi_i      (spi_mosi_i),
        .sck_rise_o  (sck_rise),
        .sck_fall_o  (sck_fall),
        .cs_start_o  (cs_start),
        .cs_active_o (cs_active),
        .mosi_o      (mosi_s)
    );

    spi_byte_deserializer u_deser (
        .sclk_i     (sclk_i),
        .rst_n      (rst_n),
        .sck_rise_i (sck_rise),
        .cs_start_i (cs_start),
        .mosi_i     (mosi_s),
        .rx_o       (rx),
        .rx_valid_o (rx_valid)
    );

    spi_cmd_decoder u_decoder (
        .sclk_i      (sclk_i),
        .rst_n       (rst_n),
        .rx_i        (rx),
        .rx_valid_i  (rx_valid),
        .cs_active_i (cs_active),
        .acc_o       (acc),
        .acc_valid_o (acc_valid),
        .cmd_o       (cmd_o)
    );

    spi_reg_bank u_regs (
        .sclk_i           (sclk_i),
        .rst_n            (rst_n),
        .acc_i            (acc),
        .acc_valid_i      (acc_valid),
        .cfg_rd_i         (cfg_rd_i),
        .cfg_bank_i       (cfg_bank_i),
        .cfg_addr_i       (cfg_addr_i),
        .cfg_rdata_o      (cfg_rdata_o),
        .pat_done_clr_i   (pat_done_clr_i),
        .erase_done_clr_i (erase_done_clr_i),
        .tx_byte_o        (tx_byte),
        .tx_load_o        (tx_load),
        .pat_done_o       (pat_done_o),
        .erase_done_o     (erase_done_o),
        .erase_ctrl_o     (erase_ctrl_o),
        .led_o            (led_o)
    );

    spi_miso_serializer u_ser (
        .sclk_i      (sclk_i),
        .rst_n       (rst_n),
        .cs_start_i  (cs_start),
        .cs_active_i (cs_active),
        .sck_fall_i  (sck_fall),
        .tx_byte_i   (tx_byte),
        .tx_load_i   (tx_load),
        .miso_o      (spi_miso_o)
    );

endmodule

/* tb/tb_spi_slave.sv */
module tb_spi_slave;
    import spi_slave_pkg::*;

    localparam int    half_cyc   = 8;
    localparam string trace_path = "tb/spi_trace.txt";

    logic       sclk_i;
    logic       rst_n;
    logic       spi_sck;
    logic       spi_cs_n;
    logic       spi_mosi;
    logic       spi_miso;
    logic       cfg_rd;
    bank_t      cfg_bank;
    byte_t      cfg_addr;
    byte_t      cfg_rdata;
    logic       pat_clr;
    logic       erase_clr;
    logic       pat_done;
    logic       erase_done;
    byte_t      erase_ctrl;
    logic [1:0] led;
    byte_t      cmd;

    // Parsed trace: record letters and their fields in file order
    byte_t       op_q[$];
    int          val_q[$];
    int unsigned byte_cnt;
    int unsigned op_cnt;
    int unsigned cycle_cnt;
    int unsigned cycle_limit;
    bit          trace_ok;

    spi_slave_top u_dut (
        .sclk_i           (sclk_i),
        .rst_n            (rst_n),
        .spi_sck_i        (spi_sck),
        .spi_cs_n_i       (spi_cs_n),
        .spi_mosi_i       (spi_mosi),
        .spi_miso_o       (spi_miso),
        .cfg_rd_i         (cfg_rd),
        .cfg_bank_i       (cfg_bank),
        .cfg_addr_i       (cfg_addr),
        .cfg_rdata_o      (cfg_rdata),
        .pat_done_clr_i   (pat_clr),
        .erase_done_clr_i (erase_clr),
        .pat_done_o       (pat_done),
        .erase_done_o     (erase_done),
        .erase_ctrl_o     (erase_ctrl),
        .led_o            (led),
        .cmd_o            (cmd)
    );

    initial begin
        sclk_i = 1'b0;
        forever #5 sclk_i = ~sclk_i;
    end

    task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                               input string what);
        if (got !== exp) begin
            $display("error at %0t: %s got %0h expected %0h", $time, what, got, exp);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    // =========================================================================
    // Trace loading
    // =========================================================================
    task automatic read_field(input int fd, output int v, inout bit ok);
        if ($fscanf(fd, " %h", v) != 1) begin
            $display("trace file is cut short or holds a bad number");
            ok = 1'b0;
        end
    endtask

    task automatic load_trace(output bit ok);
        int               fd;
        int               v;
        int               i;
        int               n_fix;
        byte_t            op;
        logic [8*160-1:0] line_buf;
        ok       = 1'b1;
        byte_cnt = 0;
        op_cnt   = 0;
        fd = $fopen(trace_path, "r");
        if (fd == 0) begin
            $display("cannot open the trace file %s", trace_path);
            ok = 1'b0;
        end
        while (ok && $fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                void'($fgets(line_buf, fd));
            end
            else begin
                case (op)
                    "W", "R", "C": n_fix = 3;
                    "F":           n_fix = 5;
                    "K":           n_fix = 2;
                    default: begin
                        $display("trace file holds an unknown record type");
                        ok = 1'b0;
                    end
                endcase
                op_q.push_back(op);
                op_cnt++;
                for (i = 0; ok && i < n_fix; i++) begin
                    read_field(fd, v, ok);
                    val_q.push_back(v);
                end
                // Burst records carry a byte count followed by that many bytes
                if (ok && (op == "W" || op == "R")) begin
                    byte_cnt += v + ((op == "R") ? 3 : 2);
                    for (i = 0; ok && i < v; i++) begin
                        read_field(fd, n_fix, ok);
                        val_q.push_back(n_fix);
                    end
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // =========================================================================
    // SPI master, mode 0
    // =========================================================================
    task automatic begin_frame();
        @(posedge sclk_i);
        spi_cs_n <= 1'b0;
        repeat (half_cyc) @(posedge sclk_i);
    endtask

    task automatic end_frame();
        @(posedge sclk_i);
        spi_sck <= 1'b0;
        repeat (half_cyc) @(posedge sclk_i);
        spi_cs_n <= 1'b1;
        repeat (half_cyc) @(posedge sclk_i);
    endtask

    task automatic shift_byte(input byte_t tx, output byte_t rx);
        int i;
        for (i = 7; i >= 0; i--) begin
            @(posedge sclk_i);
            spi_sck  <= 1'b0;
            spi_mosi <= tx[i];
            repeat (half_cyc - 1) @(posedge sclk_i);
            // MISO sampled in the middle of the cycle before the rise
            @(negedge sclk_i);
            rx[i] = spi_miso;
            @(posedge sclk_i);
            spi_sck <= 1'b1;
            repeat (half_cyc - 1) @(posedge sclk_i);
        end
    endtask

    task automatic idle_gap();
        repeat (4 + ($urandom % 13)) @(posedge sclk_i);
    endtask

    task automatic host_read(input bank_t bank, input byte_t addr, output byte_t data);
        @(posedge sclk_i);
        cfg_rd   <= 1'b1;
        cfg_bank <= bank;
        cfg_addr <= addr;
        @(posedge sclk_i);
        cfg_rd <= 1'b0;
        @(negedge sclk_i);
        data = cfg_rdata;
    endtask

    task automatic pulse_clear(input logic pat, input logic erase);
        @(posedge sclk_i);
        pat_clr   <= pat;
        erase_clr <= erase;
        @(posedge sclk_i);
        pat_clr   <= 1'b0;
        erase_clr <= 1'b0;
    endtask

    // =========================================================================
    // Trace execution
    // =========================================================================
    task automatic run_trace();
        byte_t op;
        byte_t c;
        byte_t a;
        byte_t rx;
        byte_t host;
        int    n;
        int    i;
        while (op_q.size() > 0) begin
            op = op_q.pop_front();
            c  = byte_t'(val_q.pop_front());
            a  = byte_t'(val_q.pop_front());
            // Clear records carry only two fields
            if (op != "K") begin
                n = val_q.pop_front();
            end
            else begin
                n = 0;
            end
            case (op)
                "W": begin
                    begin_frame();
                    shift_byte(c, rx);
                    check_value(rx, 8'h00, "MISO during write command");
                    shift_byte(a, rx);
                    check_value(rx, 8'h00, "MISO during write address");
                    for (i = 0; i < n; i++) begin
                        shift_byte(byte_t'(val_q.pop_front()), rx);
                        check_value(rx, 8'h00, "MISO during write data");
                    end
                    end_frame();
                    idle_gap();
                end
                "R": begin
                    begin_frame();
                    shift_byte(c, rx);
                    check_value(rx, 8'h00, "MISO during read command");
                    shift_byte(a, rx);
                    check_value(rx, 8'h00, "MISO during read address");
                    shift_byte(8'h00, rx);
                    check_value(rx, 8'h00, "read dummy byte");
                    for (i = 0; i < n; i++) begin
                        shift_byte(8'h00, rx);
                        check_value(rx, val_q.pop_front(),
                                    $sformatf("read cmd %h addr %h beat %0d", c, a, i));
                    end
                    end_frame();
                    idle_gap();
                end
                "C": begin
                    host_read(bank_t'(c), a, host);
                    check_value(host, n, $sformatf("host read bank %0d addr %h", c, a));
                end
                "F": begin
                    @(negedge sclk_i);
                    check_value(pat_done, c, "pat_done_o");
                    check_value(erase_done, a, "erase_done_o");
                    check_value(erase_ctrl, n, "erase_ctrl_o");
                    check_value(led, val_q.pop_front(), "led_o");
                    check_value(cmd, val_q.pop_front(), "cmd_o");
                end
                default: begin
                    pulse_clear(c[0], a[0]);
                end
            endcase
        end
    endtask

    // Timeout from trace length, armed once the limit is known
    initial begin
        cycle_cnt = 0;
        wait (cycle_limit != 0);
        while (cycle_cnt < cycle_limit) begin
            @(posedge sclk_i);
            cycle_cnt++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation failed");
        $fatal(1, "timeout");
    end

    initial begin
        rst_n       = 1'b0;
        spi_sck     = 1'b0;
        spi_cs_n    = 1'b1;
        spi_mosi    = 1'b0;
        cfg_rd      = 1'b0;
        cfg_bank    = bank_sys;
        cfg_addr    = '0;
        pat_clr     = 1'b0;
        erase_clr   = 1'b0;
        cycle_limit = 0;
        void'($urandom(32'h36879f52));
        load_trace(trace_ok);
        if (!trace_ok) begin
            $display("the trace file could not be used");
            $display("Simulation failed");
            $fatal(1, "trace error");
        end
        else begin
            cycle_limit = byte_cnt * 200 + op_cnt * 64 + 100;
            repeat (2) @(posedge sclk_i);
            rst_n <= 1'b1;
            repeat (4) @(posedge sclk_i);
            run_trace();
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* tb/spi_trace.txt */
# W cmd addr n data... | R cmd addr n expected... | C bank addr expected
# F pat_done erase_done erase_ctrl led cmd | K pat_clr erase_clr (all hex)
W 08 04 2 A6 3C
F 0 0 00 2 08
R 18 04 2 A6 3C
C 0 04 A6
C 0 05 3C
# EEP writes, 03 triggers erase
W 02 00 4 11 22 33 44
F 0 1 44 2 02
K 0 1
F 0 0 44 2 02
R 12 00 4 11 22 33 44
C 2 03 44
# Dropped writes and the default table
W 08 00 3 55 66 77
R 18 00 6 94 25 00 00 A6 3C
W 02 04 2 AA BB
R 12 03 3 44 0F 00
C 2 04 00
C 0 00 00
F 0 0 44 2 12
# PAT burst 00..7F
W 04 00 80
80 81 82 83 84 85 86 87 88 89 8A 8B 8C 8D 8E 8F
90 91 92 93 94 95 96 97 98 99 9A 9B 9C 9D 9E 9F
A0 A1 A2 A3 A4 A5 A6 A7 A8 A9 AA AB AC AD AE AF
B0 B1 B2 B3 B4 B5 B6 B7 B8 B9 BA BB BC BD BE BF
C0 C1 C2 C3 C4 C5 C6 C7 C8 C9 CA CB CC CD CE CF
D0 D1 D2 D3 D4 D5 D6 D7 D8 D9 DA DB DC DD DE DF
E0 E1 E2 E3 E4 E5 E6 E7 E8 E9 EA EB EC ED EE EF
F0 F1 F2 F3 F4 F5 F6 F7 F8 F9 FA FB FC FD FE FF
F 1 0 44 2 04
K 1 0
F 0 0 44 2 04
W 04 7E 2 01 02
F 0 0 44 2 04
R 14 7C 4 FC FD 01 02
W 08 04 1 01
F 0 0 44 1 08
C 0 04 01
# Bank fallback and PAT wrap
W 03 F0 2 5A C3
R 18 F0 2 5A C3
R 1F F0 2 5A C3
F 0 0 44 1 1F
W 04 FE 4 E1 E2 E3 E4
R 14 FE 4 E1 E2 E3 E4
C 1 FF E2
C 1 02 82
F 0 0 44 1 14

/* tb.f */
src/spi_slave_pkg.sv
src/spi_bus_sampler.sv
src/spi_byte_deserializer.sv
src/spi_cmd_decoder.sv
src/spi_reg_bank.sv
src/spi_miso_serializer.sv
src/spi_slave_top.sv
tb/tb_spi_slave.sv

/* Bender.yml */
package:
  name: spi_slave

sources:
  - src/spi_slave_pkg.sv
  - src/spi_bus_sampler.sv
  - src/spi_byte_deserializer.sv
  - src/spi_cmd_decoder.sv
  - src/spi_reg_bank.sv
  - src/spi_miso_serializer.sv
  - src/spi_slave_top.sv
  - target: test
    files:
      - tb/tb_spi_slave.sv
